// ==== hdl/dsp_defines.svh ====
/*
 * Widths, output-select codes and shift width of the MAC slice
 */
`ifndef DSP_DEFINES_SVH
`define DSP_DEFINES_SVH

// Operand, accumulator and output widths of the primitive
`define DSP_A_W      20
`define DSP_B_W      18
`define DSP_ACC_W    64
`define DSP_Z_W      38

`define DSP_SHIFT_W  6
`define DSP_SEL_W    3

// Low two bits of output_select
`define DSP_OSEL_MULT  3'd0
`define DSP_OSEL_ACC   3'd1
`define DSP_OSEL_ADD   3'd2

// Bit index of output_select that picks the output register
`define DSP_OSEL_REG   2

`endif

// ==== hdl/dsp_pkg.sv ====
/*
 * Vector types shared along the MAC datapath
 */
package dsp_pkg;

    `include "dsp_defines.svh"

    // Multiplier operands
    typedef logic [`DSP_A_W-1:0] operand_a_t;
    typedef logic [`DSP_B_W-1:0] operand_b_t;

    // Extended product, adder result and accumulator
    typedef logic [`DSP_ACC_W-1:0] acc_t;

    // Value presented on z
    typedef logic [`DSP_Z_W-1:0] result_t;

    // Right shift amount after rounding
    typedef logic [`DSP_SHIFT_W-1:0] shift_t;

    // Output mode code
    typedef logic [`DSP_SEL_W-1:0] out_sel_t;

endpackage

// ==== hdl/dsp_input_stage.sv ====
/*
 * Input stage: register bank for operands and controls, bypass mux
 */
`timescale 1ns/100ps

module dsp_input_stage (
    input  logic                clock_i,
    input  logic                s_reset,
    input  logic                register_inputs_i,
    input  dsp_pkg::operand_a_t a_i,
    input  dsp_pkg::operand_b_t b_i,
    input  logic                unsigned_a_i,
    input  logic                unsigned_b_i,
    input  logic                accumulate_i,
    input  logic                load_acc_i,
    input  logic                subtract_i,
    input  logic                round_i,
    input  logic                saturate_enable_i,
    input  dsp_pkg::shift_t     shift_right_i,
    output dsp_pkg::operand_a_t a_o,
    output dsp_pkg::operand_b_t b_o,
    output logic                unsigned_a_o,
    output logic                unsigned_b_o,
    output logic                accumulate_o,
    output logic                load_acc_o,
    output logic                subtract_o,
    output logic                round_o,
    output logic                saturate_enable_o,
    output dsp_pkg::shift_t     shift_right_o
);

    dsp_pkg::operand_a_t a_q;
    dsp_pkg::operand_b_t b_q;
    logic                unsigned_a_q;
    logic                unsigned_b_q;
    logic                accumulate_q;
    logic                load_acc_q;
    logic                subtract_q;
    logic                round_q;
    logic                saturate_enable_q;
    dsp_pkg::shift_t     shift_right_q;

    // One bank for everything, shift included
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            a_q               <= '0;
            b_q               <= '0;
            unsigned_a_q      <= 1'b0;
            unsigned_b_q      <= 1'b0;
            accumulate_q      <= 1'b0;
            load_acc_q        <= 1'b0;
            subtract_q        <= 1'b0;
            round_q           <= 1'b0;
            saturate_enable_q <= 1'b0;
            shift_right_q     <= '0;
        end else begin
            a_q               <= a_i;
            b_q               <= b_i;
            unsigned_a_q      <= unsigned_a_i;
            unsigned_b_q      <= unsigned_b_i;
            accumulate_q      <= accumulate_i;
            load_acc_q        <= load_acc_i;
            subtract_q        <= subtract_i;
            round_q           <= round_i;
            saturate_enable_q <= saturate_enable_i;
            shift_right_q     <= shift_right_i;
        end
    end

    // Registered or direct path
    assign a_o               = register_inputs_i ? a_q               : a_i;
    assign b_o               = register_inputs_i ? b_q               : b_i;
    assign unsigned_a_o      = register_inputs_i ? unsigned_a_q      : unsigned_a_i;
    assign unsigned_b_o      = register_inputs_i ? unsigned_b_q      : unsigned_b_i;
    assign accumulate_o      = register_inputs_i ? accumulate_q      : accumulate_i;
    assign load_acc_o        = register_inputs_i ? load_acc_q        : load_acc_i;
    assign subtract_o        = register_inputs_i ? subtract_q        : subtract_i;
    assign round_o           = register_inputs_i ? round_q           : round_i;
    assign saturate_enable_o = register_inputs_i ? saturate_enable_q : saturate_enable_i;
    assign shift_right_o     = register_inputs_i ? shift_right_q     : shift_right_i;

    // Controls reaching the datapath must be defined once out of reset
    a_ctrl_known: assert property (@(posedge clock_i) disable iff (s_reset)
        !$isunknown({unsigned_a_o, unsigned_b_o, accumulate_o, load_acc_o,
                     subtract_o, round_o, saturate_enable_o, shift_right_o}));

endmodule

// ==== hdl/dsp_multiplier.sv ====
/*
 * 20x18 multiplier with per-operand sign control and extension to 64 bits
 */
`timescale 1ns/100ps

`include "dsp_defines.svh"

module dsp_multiplier (
    input  dsp_pkg::operand_a_t a_i,
    input  dsp_pkg::operand_b_t b_i,
    input  logic                unsigned_a_i,
    input  logic                unsigned_b_i,
    output dsp_pkg::acc_t       product_o
);

    localparam int PROD_W = `DSP_A_W + `DSP_B_W;

    logic                neg_a;
    logic                neg_b;
    dsp_pkg::operand_a_t mag_a;
    dsp_pkg::operand_b_t mag_b;
    logic [PROD_W-1:0]   mag_prod;
    logic [PROD_W-1:0]   prod;
    logic                unsigned_mode;

    // An operand counts as negative only when it is signed
    assign neg_a = a_i[`DSP_A_W-1] & ~unsigned_a_i;
    assign neg_b = b_i[`DSP_B_W-1] & ~unsigned_b_i;

    // Magnitudes, the most negative value still fits as unsigned
    assign mag_a = neg_a ? (~a_i + 1'b1) : a_i;
    assign mag_b = neg_b ? (~b_i + 1'b1) : b_i;

    assign mag_prod = PROD_W'(mag_a) * PROD_W'(mag_b);

    // Restore the sign of the product
    assign prod = (neg_a ^ neg_b) ? (~mag_prod + 1'b1) : mag_prod;

    assign unsigned_mode = unsigned_a_i & unsigned_b_i;

    // Zero extend only when both operands are unsigned
    always_comb begin
        if (unsigned_mode) begin
            product_o = {{(`DSP_ACC_W-PROD_W){1'b0}}, prod};
        end else begin
            product_o = {{(`DSP_ACC_W-PROD_W){prod[PROD_W-1]}}, prod};
        end
    end

endmodule

// ==== hdl/dsp_accumulator.sv ====
/*
 * Add/subtract stage and 64-bit accumulator register
 */
`timescale 1ns/100ps

module dsp_accumulator (
    input  logic          clock_i,
    input  logic          s_reset,
    input  dsp_pkg::acc_t product_i,
    input  logic          subtract_i,
    input  logic          accumulate_i,
    input  logic          load_acc_i,
    output dsp_pkg::acc_t sum_o,
    output dsp_pkg::acc_t acc_o
);

    dsp_pkg::acc_t addend;
    dsp_pkg::acc_t base;
    dsp_pkg::acc_t acc_q;

    // Two's complement negation for subtract
    assign addend = subtract_i ? (~product_i + 1'b1) : product_i;

    // Restart adds zero instead of the stored value
    assign base = accumulate_i ? acc_q : '0;

    // Wraps modulo 2^64
    assign sum_o = addend + base;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            acc_q <= '0;
        end else if (load_acc_i) begin
            acc_q <= sum_o;
        end
    end

    assign acc_o = acc_q;

    // Never load an unknown product
    a_load_known: assert property (@(posedge clock_i) disable iff (s_reset)
        load_acc_i |-> !$isunknown(product_i));

endmodule

// ==== hdl/dsp_output_stage.sv ====
/*
 * Output stage: round, shift and saturate, mode select, output register
 */
`timescale 1ns/100ps

`include "dsp_defines.svh"

module dsp_output_stage (
    input  logic              clock_i,
    input  logic              s_reset,
    input  dsp_pkg::out_sel_t output_select_i,
    input  dsp_pkg::acc_t     product_i,
    input  dsp_pkg::acc_t     sum_i,
    input  dsp_pkg::acc_t     acc_i,
    input  logic              round_i,
    input  logic              saturate_enable_i,
    input  dsp_pkg::shift_t   shift_right_i,
    input  logic              unsigned_i,
    output dsp_pkg::result_t  z_o
);

    localparam int HIGH_W = `DSP_ACC_W - `DSP_Z_W + 1;

    dsp_pkg::acc_t     pre_value;
    dsp_pkg::acc_t     round_bit;
    dsp_pkg::acc_t     rounded;
    dsp_pkg::acc_t     shifted;
    logic [HIGH_W-1:0] high_bits;
    dsp_pkg::result_t  sat_value;
    dsp_pkg::result_t  z_comb;
    dsp_pkg::result_t  z_q;
    logic              sel_mult;

    // Bit 1 picks the adder result over the stored accumulator
    assign pre_value = output_select_i[1] ? sum_i : acc_i;

    // Half of the last kept bit
    assign round_bit = {{(`DSP_ACC_W-1){1'b0}}, 1'b1} << (shift_right_i - 1'b1);
    assign rounded   = (round_i && (shift_right_i != '0)) ? (pre_value + round_bit) : pre_value;

    always_comb begin
        if (unsigned_i) begin
            shifted = rounded >> shift_right_i;
        end else begin
            shifted = $signed(rounded) >>> shift_right_i;
        end
    end

    // Sign bit of the result and everything above it
    assign high_bits = shifted[`DSP_ACC_W-1:`DSP_Z_W-1];

    always_comb begin
        sat_value = shifted[`DSP_Z_W-1:0];
        if (saturate_enable_i) begin
            if (unsigned_i) begin
                if (|shifted[`DSP_ACC_W-1:`DSP_Z_W]) begin
                    sat_value = '1;
                end
            end else if ((|high_bits) && !(&high_bits)) begin
                // Clamp toward the sign of the full value
                sat_value = {shifted[`DSP_ACC_W-1], {(`DSP_Z_W-1){~shifted[`DSP_ACC_W-1]}}};
            end
        end
    end

    // Modes 0 and 4 bypass the post-processing
    assign sel_mult = ({1'b0, output_select_i[1:0]} == `DSP_OSEL_MULT);
    assign z_comb   = sel_mult ? product_i[`DSP_Z_W-1:0] : sat_value;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            z_q <= '0;
        end else begin
            z_q <= z_comb;
        end
    end

    assign z_o = output_select_i[`DSP_OSEL_REG] ? z_q : z_comb;

    // Modes 3 and 7 are not supported by this slice
    a_sel_legal: assert property (@(posedge clock_i) disable iff (s_reset)
        {1'b0, output_select_i[1:0]} inside {`DSP_OSEL_MULT, `DSP_OSEL_ACC, `DSP_OSEL_ADD});

endmodule

// ==== hdl/dsp_mac_top.sv ====
/*
 * MAC slice top: input stage, multiplier, accumulator, output stage
 */
`timescale 1ns/100ps

module dsp_mac_top (
    input  logic                clock_i,
    input  logic                s_reset,
    input  logic                register_inputs_i,
    input  dsp_pkg::out_sel_t   output_select_i,
    input  dsp_pkg::operand_a_t a_i,
    input  dsp_pkg::operand_b_t b_i,
    input  logic                unsigned_a_i,
    input  logic                unsigned_b_i,
    input  logic                accumulate_i,
    input  logic                load_acc_i,
    input  logic                subtract_i,
    input  logic                round_i,
    input  logic                saturate_enable_i,
    input  dsp_pkg::shift_t     shift_right_i,
    output dsp_pkg::result_t    z_o
);

    dsp_pkg::operand_a_t stage_a;
    dsp_pkg::operand_b_t stage_b;
    logic                stage_unsigned_a;
    logic                stage_unsigned_b;
    logic                stage_accumulate;
    logic                stage_load_acc;
    logic                stage_subtract;
    logic                stage_round;
    logic                stage_saturate;
    dsp_pkg::shift_t     stage_shift;
    logic                unsigned_mode;
    dsp_pkg::acc_t       product;
    dsp_pkg::acc_t       sum;
    dsp_pkg::acc_t       acc;

    dsp_input_stage dsp_input_stage_inst (
        .clock_i           (clock_i),
        .s_reset           (s_reset),
        .register_inputs_i (register_inputs_i),
        .a_i               (a_i),
        .b_i               (b_i),
        .unsigned_a_i      (unsigned_a_i),
        .unsigned_b_i      (unsigned_b_i),
        .accumulate_i      (accumulate_i),
        .load_acc_i        (load_acc_i),
        .subtract_i        (subtract_i),
        .round_i           (round_i),
        .saturate_enable_i (saturate_enable_i),
        .shift_right_i     (shift_right_i),
        .a_o               (stage_a),
        .b_o               (stage_b),
        .unsigned_a_o      (stage_unsigned_a),
        .unsigned_b_o      (stage_unsigned_b),
        .accumulate_o      (stage_accumulate),
        .load_acc_o        (stage_load_acc),
        .subtract_o        (stage_subtract),
        .round_o           (stage_round),
        .saturate_enable_o (stage_saturate),
        .shift_right_o     (stage_shift)
    );

    // Logical shift and unsigned clamp need both operands unsigned
    assign unsigned_mode = stage_unsigned_a & stage_unsigned_b;

    dsp_multiplier dsp_multiplier_inst (
        .a_i          (stage_a),
        .b_i          (stage_b),
        .unsigned_a_i (stage_unsigned_a),
        .unsigned_b_i (stage_unsigned_b),
        .product_o    (product)
    );

    dsp_accumulator dsp_accumulator_inst (
        .clock_i      (clock_i),
        .s_reset      (s_reset),
        .product_i    (product),
        .subtract_i   (stage_subtract),
        .accumulate_i (stage_accumulate),
        .load_acc_i   (stage_load_acc),
        .sum_o        (sum),
        .acc_o        (acc)
    );

    dsp_output_stage dsp_output_stage_inst (
        .clock_i           (clock_i),
        .s_reset           (s_reset),
        .output_select_i   (output_select_i),
        .product_i         (product),
        .sum_i             (sum),
        .acc_i             (acc),
        .round_i           (stage_round),
        .saturate_enable_i (stage_saturate),
        .shift_right_i     (stage_shift),
        .unsigned_i        (unsigned_mode),
        .z_o               (z_o)
    );

endmodule

// ==== dv/dsp_mac_tb.sv ====
/*
 * Testbench for the MAC slice: reference model, directed tests, summary
 */
`timescale 1ns/100ps

`include "dsp_defines.svh"

module dsp_mac_tb;

    localparam dsp_pkg::out_sel_t MODE_MULT     = `DSP_OSEL_MULT;
    localparam dsp_pkg::out_sel_t MODE_ACC      = `DSP_OSEL_ACC;
    localparam dsp_pkg::out_sel_t MODE_ADD      = `DSP_OSEL_ADD;
    localparam dsp_pkg::out_sel_t MODE_MULT_REG = `DSP_OSEL_MULT | (3'd1 << `DSP_OSEL_REG);
    localparam dsp_pkg::out_sel_t MODE_ACC_REG  = `DSP_OSEL_ACC | (3'd1 << `DSP_OSEL_REG);

    localparam dsp_pkg::acc_t      Z_MASK     = (64'd1 << `DSP_Z_W) - 64'd1;
    localparam dsp_pkg::acc_t      UNS_MAX    = Z_MASK;
    localparam logic signed [63:0] SIGNED_MAX = (64'sd1 <<< (`DSP_Z_W - 1)) - 64'sd1;
    localparam logic signed [63:0] SIGNED_MIN = -(64'sd1 <<< (`DSP_Z_W - 1));

    // Tests take roughly 170 cycles
    localparam int TEST_CYCLES = 200;
    localparam int MAX_CYCLES  = 10 * TEST_CYCLES;

    logic                clock_i;
    logic                s_reset;
    logic                register_inputs_i;
    dsp_pkg::out_sel_t   output_select_i;
    dsp_pkg::operand_a_t a_i;
    dsp_pkg::operand_b_t b_i;
    logic                unsigned_a_i;
    logic                unsigned_b_i;
    logic                accumulate_i;
    logic                load_acc_i;
    logic                subtract_i;
    logic                round_i;
    logic                saturate_enable_i;
    dsp_pkg::shift_t     shift_right_i;
    dsp_pkg::result_t    z_o;

    int check_count = 0;
    int error_count = 0;
    int test_checks_start = 0;
    int test_errors_start = 0;
    int cycle_count = 0;

    dsp_mac_top dsp_mac_top_inst (
        .clock_i           (clock_i),
        .s_reset           (s_reset),
        .register_inputs_i (register_inputs_i),
        .output_select_i   (output_select_i),
        .a_i               (a_i),
        .b_i               (b_i),
        .unsigned_a_i      (unsigned_a_i),
        .unsigned_b_i      (unsigned_b_i),
        .accumulate_i      (accumulate_i),
        .load_acc_i        (load_acc_i),
        .subtract_i        (subtract_i),
        .round_i           (round_i),
        .saturate_enable_i (saturate_enable_i),
        .shift_right_i     (shift_right_i),
        .z_o               (z_o)
    );

    initial begin
        clock_i = 1'b0;
        forever #10 clock_i = ~clock_i;
    end

    always @(posedge clock_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // Exact product of the extended operands, wrapped to 64 bits
    function automatic dsp_pkg::acc_t ref_product(input dsp_pkg::operand_a_t a_val,
            input dsp_pkg::operand_b_t b_val, input logic uns_a, input logic uns_b);
        logic signed [63:0] ext_a;
        logic signed [63:0] ext_b;
        ext_a = {{(`DSP_ACC_W-`DSP_A_W){~uns_a & a_val[`DSP_A_W-1]}}, a_val};
        ext_b = {{(`DSP_ACC_W-`DSP_B_W){~uns_b & b_val[`DSP_B_W-1]}}, b_val};
        return ext_a * ext_b;
    endfunction

    // Round, shift and saturate, low 38 bits returned
    function automatic dsp_pkg::acc_t ref_post(input dsp_pkg::acc_t value, input logic rnd,
            input dsp_pkg::shift_t shift, input logic sat, input logic uns);
        dsp_pkg::acc_t      v;
        logic signed [63:0] sv;
        v = value;
        if (rnd && shift != 6'd0) begin
            v = v + (64'd1 << (shift - 6'd1));
        end
        if (uns) begin
            v = v >> shift;
        end else begin
            sv = v;
            sv = sv >>> shift;
            v = sv;
        end
        if (sat) begin
            sv = v;
            if (uns && v > UNS_MAX) begin
                v = UNS_MAX;
            end else if (!uns && sv > SIGNED_MAX) begin
                v = SIGNED_MAX;
            end else if (!uns && sv < SIGNED_MIN) begin
                v = SIGNED_MIN;
            end
        end
        return v & Z_MASK;
    endfunction

    task automatic check_value(input string test_name, input dsp_pkg::acc_t expected,
                               input dsp_pkg::acc_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch in %s at %0t: expected %h, actual %h",
                     test_name, $time, expected, actual);
        end
    endtask

    task automatic check_z(input string test_name, input dsp_pkg::acc_t expected);
        check_value(test_name, expected & Z_MASK, dsp_pkg::acc_t'(z_o));
    endtask

    task automatic start_test();
        test_checks_start = check_count;
        test_errors_start = error_count;
    endtask

    task automatic end_test(input string test_name);
        $display("test %-18s done: %0d checks, %0d errors", test_name,
                 check_count - test_checks_start, error_count - test_errors_start);
    endtask

    // Inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clock_i);
        #2;
    endtask

    task automatic idle_inputs();
        a_i               = '0;
        b_i               = '0;
        unsigned_a_i      = 1'b0;
        unsigned_b_i      = 1'b0;
        accumulate_i      = 1'b0;
        load_acc_i        = 1'b0;
        subtract_i        = 1'b0;
        round_i           = 1'b0;
        saturate_enable_i = 1'b0;
        shift_right_i     = '0;
    endtask

    task automatic drive_operands(input logic uns_a, input logic uns_b);
        a_i          = dsp_pkg::operand_a_t'($urandom);
        b_i          = dsp_pkg::operand_b_t'($urandom);
        unsigned_a_i = uns_a;
        unsigned_b_i = uns_b;
    endtask

    task automatic apply_reset();
        s_reset = 1'b1;
        repeat (5) @(posedge clock_i);
        #2;
        s_reset = 1'b0;
    endtask

    task automatic test_reset_state();
        dsp_pkg::acc_t expected;
        start_test();
        output_select_i = MODE_ACC_REG;
        @(negedge clock_i);
        check_z("reset_state", '0);
        next_cycle();
        a_i          = 20'h0_04D2;
        b_i          = 18'h3_FDC9;
        load_acc_i   = 1'b1;
        accumulate_i = 1'b0;
        expected     = ref_product(a_i, b_i, 1'b0, 1'b0);
        next_cycle();
        // Accumulator loaded, output register one cycle behind
        load_acc_i = 1'b0;
        @(negedge clock_i);
        check_z("reset_state", '0);
        next_cycle();
        @(negedge clock_i);
        check_z("reset_state", expected);
        next_cycle();
        idle_inputs();
        end_test("reset_state");
    endtask

    task automatic test_product();
        dsp_pkg::acc_t previous;
        int i;
        start_test();
        output_select_i = MODE_MULT;
        for (i = 0; i < 40; i++) begin
            drive_operands(i[0], i[1]);
            @(negedge clock_i);
            check_z("product", ref_product(a_i, b_i, unsigned_a_i, unsigned_b_i));
            next_cycle();
        end
        output_select_i = MODE_MULT_REG;
        for (i = 0; i < 20; i++) begin
            drive_operands(i[1], i[0]);
            @(negedge clock_i);
            if (i > 0) begin
                check_z("product_reg", previous);
            end
            previous = ref_product(a_i, b_i, unsigned_a_i, unsigned_b_i);
            next_cycle();
        end
        @(negedge clock_i);
        check_z("product_reg", previous);
        next_cycle();
        idle_inputs();
        end_test("product");
    endtask

    task automatic test_accumulate();
        dsp_pkg::acc_t acc_model;
        dsp_pkg::acc_t next_sum;
        dsp_pkg::acc_t product;
        int i;
        start_test();
        acc_model       = '0;
        output_select_i = MODE_ACC;
        // Restart from a zero product
        load_acc_i = 1'b1;
        next_cycle();
        accumulate_i = 1'b1;
        for (i = 0; i < 30; i++) begin
            if (i == 20) begin
                output_select_i = MODE_ADD;
            end
            drive_operands(i[2], i[3]);
            subtract_i = 1'($urandom);
            product    = ref_product(a_i, b_i, unsigned_a_i, unsigned_b_i);
            next_sum   = subtract_i ? (acc_model - product) : (acc_model + product);
            @(negedge clock_i);
            if (i < 20) begin
                check_z("accumulate", acc_model);
            end else begin
                check_z("accumulate_next", next_sum);
            end
            acc_model = next_sum;
            next_cycle();
        end
        load_acc_i      = 1'b0;
        output_select_i = MODE_ACC;
        @(negedge clock_i);
        check_z("accumulate", acc_model);
        next_cycle();
        idle_inputs();
        end_test("accumulate");
    endtask

    task automatic test_round_shift();
        dsp_pkg::operand_a_t a_list[2] = '{20'h8_1357, 20'h3_FFFF};
        dsp_pkg::operand_b_t b_list[2] = '{18'h2_ACE1, 18'h1_0001};
        dsp_pkg::shift_t     shift_list[3] = '{6'd1, 6'd5, 6'd20};
        dsp_pkg::acc_t       expected;
        int p;
        int u;
        int s;
        int r;
        start_test();
        // Unstored adder result equals the product on restart
        output_select_i = MODE_ADD;
        for (p = 0; p < 2; p++) begin
            for (u = 0; u < 2; u++) begin
                for (s = 0; s < 3; s++) begin
                    for (r = 0; r < 2; r++) begin
                        a_i           = a_list[p];
                        b_i           = b_list[p];
                        unsigned_a_i  = u[0];
                        unsigned_b_i  = u[0];
                        shift_right_i = shift_list[s];
                        round_i       = r[0];
                        expected = ref_post(ref_product(a_i, b_i, u[0], u[0]), r[0],
                                            shift_list[s], 1'b0, u[0]);
                        @(negedge clock_i);
                        check_z("round_shift", expected);
                        next_cycle();
                    end
                end
            end
        end
        idle_inputs();
        end_test("round_shift");
    endtask

    task automatic saturate_case(input string name, input dsp_pkg::operand_a_t a_val,
            input dsp_pkg::operand_b_t b_val, input logic uns, input int count);
        dsp_pkg::acc_t total;
        int k;
        output_select_i = MODE_ACC;
        a_i             = a_val;
        b_i             = b_val;
        unsigned_a_i    = uns;
        unsigned_b_i    = uns;
        load_acc_i      = 1'b1;
        total           = '0;
        for (k = 0; k < count; k++) begin
            accumulate_i = (k != 0);
            total        = total + ref_product(a_val, b_val, uns, uns);
            next_cycle();
        end
        load_acc_i        = 1'b0;
        accumulate_i      = 1'b0;
        saturate_enable_i = 1'b1;
        @(negedge clock_i);
        check_z(name, ref_post(total, 1'b0, 6'd0, 1'b1, uns));
        next_cycle();
        saturate_enable_i = 1'b0;
        @(negedge clock_i);
        check_z(name, ref_post(total, 1'b0, 6'd0, 1'b0, uns));
        next_cycle();
    endtask

    task automatic test_saturate();
        start_test();
        saturate_case("saturate_pos", 20'h7_FFFF, 18'h1_FFFF, 1'b0, 4);
        saturate_case("saturate_neg", 20'h8_0000, 18'h1_FFFF, 1'b0, 4);
        saturate_case("saturate_uns", 20'hF_FFFF, 18'h3_FFFF, 1'b1, 2);
        saturate_case("saturate_in_range", 20'h0_1234, 18'h0_0567, 1'b0, 3);
        idle_inputs();
        end_test("saturate");
    endtask

    task automatic test_registered_inputs();
        dsp_pkg::acc_t previous;
        int i;
        start_test();
        register_inputs_i = 1'b1;
        output_select_i   = MODE_MULT;
        for (i = 0; i < 16; i++) begin
            drive_operands(i[0], i[1]);
            @(negedge clock_i);
            if (i > 0) begin
                check_z("registered_inputs", previous);
            end
            previous = ref_product(a_i, b_i, unsigned_a_i, unsigned_b_i);
            next_cycle();
        end
        idle_inputs();
        @(negedge clock_i);
        check_z("registered_inputs", previous);
        next_cycle();
        register_inputs_i = 1'b0;
        end_test("registered_inputs");
    endtask

    initial begin
        void'($urandom(32'h676d));
        idle_inputs();
        register_inputs_i = 1'b0;
        output_select_i   = MODE_ACC_REG;
        apply_reset();
        test_reset_state();
        test_product();
        test_accumulate();
        test_round_shift();
        test_saturate();
        test_registered_inputs();
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/dsp_pkg.sv
hdl/dsp_input_stage.sv
hdl/dsp_multiplier.sv
hdl/dsp_accumulator.sv
hdl/dsp_output_stage.sv
hdl/dsp_mac_top.sv
dv/dsp_mac_tb.sv

// ==== Makefile ====
# Verilator lint, build and simulation of the MAC slice testbench

VERILATOR  ?= verilator
TOP        ?= dsp_mac_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Something failed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run status is kept, then the log decides pass or fail
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
